// ==== hdc_pkg.sv ====
package hdc_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;
    // one 32-bit word per item vector
    localparam int HV_W        = 32;
    // item index and item count
    localparam int ITEM_W      = 16;
    // word index, address bits 9..2
    localparam int REG_IDX_W   = 8;

    // ==================================================
    // shared types
    // ==================================================
    typedef logic [AXIL_DATA_W-1:0] data_t;
    typedef logic [HV_W-1:0]        hv_t;
    typedef logic [ITEM_W-1:0]      item_idx_t;
    typedef logic [REG_IDX_W-1:0]   reg_idx_t;

    // prng reload value, must never be zero
    localparam hv_t        HV_SEED   = 32'h2545_f491;
    // OKAY is the only response this slave gives
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ==================================================
    // encodings
    // ==================================================
    // bus handshake states
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_aw_held   = 3'd1,
        st_w_held    = 3'd2,
        st_wr_commit = 3'd3,
        st_wr_resp   = 3'd4,
        st_rd_fetch  = 3'd5,
        st_rd_resp   = 3'd6
    } axil_state_e;

    // register word indices, byte address is index * 4
    typedef enum logic [REG_IDX_W-1:0] {
        reg_ctrl     = 8'd0,
        reg_item_num = 8'd1,
        reg_hv       = 8'd2
    } reg_addr_e;

endpackage

// ==== reg_bus_if.sv ====
`timescale 1ns/1ps

interface reg_bus_if;

    // write side, one-cycle strobe with index and word
    logic              wr_en;
    hdc_pkg::reg_idx_t wr_idx;
    hdc_pkg::data_t    wr_data;

    // read side, data is registered on the strobe
    logic              rd_en;
    hdc_pkg::reg_idx_t rd_idx;
    hdc_pkg::data_t    rd_data;

    // bus state machine side
    modport fsm (
        output wr_en, wr_idx, wr_data, rd_en, rd_idx,
        input  rd_data
    );

    // register file side
    modport regs (
        input  wr_en, wr_idx, wr_data, rd_en, rd_idx,
        output rd_data
    );

endinterface

// ==== axil_fsm.sv ====
`timescale 1ns/1ps

module axil_fsm (
    input  logic                            S_AXI_ACLK,
    input  logic                            S_AXI_ARESETN,
    // write address
    input  logic [hdc_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    // write data
    input  hdc_pkg::data_t                  s_axi_wdata,
    input  logic [3:0]                      s_axi_wstrb,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,
    // write response
    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,
    // read address
    input  logic [hdc_pkg::AXIL_ADDR_W-1:0] s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    // read response, data comes from the register file
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready,
    reg_bus_if.fsm                          bus
);

    hdc_pkg::axil_state_e state;

    // latched transaction fields
    hdc_pkg::reg_idx_t wr_idx_q;
    hdc_pkg::reg_idx_t rd_idx_q;
    logic [1:0]        wr_region_q;
    logic [1:0]        rd_region_q;
    hdc_pkg::data_t    wr_data_q;

    // handshakes that complete this cycle
    logic aw_take;
    logic w_take;
    logic ar_take;

    // ==================================================
    // handshake outputs
    // ==================================================
    // address and data can arrive in either order
    assign s_axi_awready = (state == hdc_pkg::st_idle) || (state == hdc_pkg::st_w_held);
    assign s_axi_wready  = (state == hdc_pkg::st_idle) || (state == hdc_pkg::st_aw_held);
    // write wins in idle, so ar is only offered with no write pending
    assign s_axi_arready = (state == hdc_pkg::st_idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == hdc_pkg::st_wr_resp);
    assign s_axi_rvalid  = (state == hdc_pkg::st_rd_resp);
    assign s_axi_bresp   = hdc_pkg::RESP_OKAY;
    assign s_axi_rresp   = hdc_pkg::RESP_OKAY;

    assign aw_take = s_axi_awready && s_axi_awvalid;
    assign w_take  = s_axi_wready && s_axi_wvalid;
    assign ar_take = s_axi_arready && s_axi_arvalid;

    // ==================================================
    // state register
    // ==================================================
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= hdc_pkg::st_idle;
        end else begin
            case (state)
                hdc_pkg::st_idle: begin
                    if (aw_take && w_take) begin
                        state <= hdc_pkg::st_wr_commit;
                    end else if (aw_take) begin
                        state <= hdc_pkg::st_aw_held;
                    end else if (w_take) begin
                        state <= hdc_pkg::st_w_held;
                    end else if (ar_take) begin
                        state <= hdc_pkg::st_rd_fetch;
                    end
                end
                // waiting for the missing half of the write
                hdc_pkg::st_aw_held: begin
                    if (w_take) begin
                        state <= hdc_pkg::st_wr_commit;
                    end
                end
                hdc_pkg::st_w_held: begin
                    if (aw_take) begin
                        state <= hdc_pkg::st_wr_commit;
                    end
                end
                hdc_pkg::st_wr_commit: state <= hdc_pkg::st_wr_resp;
                hdc_pkg::st_wr_resp: begin
                    if (s_axi_bready) begin
                        state <= hdc_pkg::st_idle;
                    end
                end
                // one fetch cycle, register file loads rd_data
                hdc_pkg::st_rd_fetch: state <= hdc_pkg::st_rd_resp;
                hdc_pkg::st_rd_resp: begin
                    if (s_axi_rready) begin
                        state <= hdc_pkg::st_idle;
                    end
                end
                default: state <= hdc_pkg::st_idle;
            endcase
        end
    end

    // ==================================================
    // address and data capture
    // ==================================================
    // byte strobes ignored, every write is a full word
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_take) begin
            wr_idx_q    <= s_axi_awaddr[9:2];
            wr_region_q <= s_axi_awaddr[11:10];
        end
        if (w_take) begin
            wr_data_q <= s_axi_wdata;
        end
        if (ar_take) begin
            rd_idx_q    <= s_axi_araddr[9:2];
            rd_region_q <= s_axi_araddr[11:10];
        end
    end

    // write strobe only inside the register window
    assign bus.wr_en   = (state == hdc_pkg::st_wr_commit) && (wr_region_q == 2'b00);
    assign bus.wr_idx  = wr_idx_q;
    assign bus.wr_data = wr_data_q;

    // reads outside the window land on an unmapped word and return zero
    assign bus.rd_en  = (state == hdc_pkg::st_rd_fetch);
    assign bus.rd_idx = (rd_region_q == 2'b00) ? rd_idx_q : '1;

    // ==================================================
    // checks
    // ==================================================
    a_one_resp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid));

    // strobe right after the accepting edge, response one cycle later
    a_wr_strobe: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bus.wr_en |-> $past(aw_take || w_take) ##1 s_axi_bvalid);
    a_rd_strobe: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bus.rd_en |-> $past(ar_take) ##1 s_axi_rvalid);

    // register file must hold read data while the master stalls
    a_rdata_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> $stable(bus.rd_data));

endmodule

// ==== hdc_regs.sv ====
`timescale 1ns/1ps

module hdc_regs (
    input  logic               S_AXI_ACLK,
    input  logic               S_AXI_ARESETN,
    reg_bus_if.regs            bus,
    input  logic               item_done,
    input  hdc_pkg::hv_t       rand_word,
    output logic               gen,
    output hdc_pkg::item_idx_t item_num,
    output hdc_pkg::data_t     rdata
);

    // captured item hypervector, read only from the bus
    hdc_pkg::hv_t   hv_q;
    hdc_pkg::data_t rd_mux;

    // write decode
    logic wr_ctrl;
    logic wr_count;

    assign wr_ctrl  = bus.wr_en && (bus.wr_idx == hdc_pkg::reg_ctrl);
    assign wr_count = bus.wr_en && (bus.wr_idx == hdc_pkg::reg_item_num);

    // ==================================================
    // control and count
    // ==================================================
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen      <= 1'b0;
            item_num <= '0;
        end else begin
            // software write beats the self clear on the same edge
            if (wr_ctrl) begin
                gen <= bus.wr_data[0];
            end else if (item_done) begin
                gen <= 1'b0;
            end
            // low 16 bits only
            if (wr_count) begin
                item_num <= bus.wr_data[hdc_pkg::ITEM_W-1:0];
            end
        end
    end

    // grab the requested item's vector
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            hv_q <= '0;
        end else if (item_done) begin
            hv_q <= rand_word;
        end
    end

    // ==================================================
    // read path
    // ==================================================
    // zero-extended, unmapped words read 0
    always_comb begin
        rd_mux = '0;
        case (bus.rd_idx)
            hdc_pkg::reg_ctrl:     rd_mux[0] = gen;
            hdc_pkg::reg_item_num: rd_mux[hdc_pkg::ITEM_W-1:0] = item_num;
            hdc_pkg::reg_hv:       rd_mux = hdc_pkg::data_t'(hv_q);
            default:               rd_mux = '0;
        endcase
    end

    // loaded in the fetch cycle, held through the response
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rdata <= '0;
        end else if (bus.rd_en) begin
            rdata <= rd_mux;
        end
    end

    assign bus.rd_data = rdata;

    // counter may only finish during a run
    a_done_in_run: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        item_done |-> gen);

endmodule

// ==== item_counter.sv ====
`timescale 1ns/1ps

module item_counter (
    input  logic               S_AXI_ACLK,
    input  logic               S_AXI_ARESETN,
    input  logic               gen,
    input  hdc_pkg::item_idx_t item_num,
    output logic               item_done
);

    // index of the item the prng shows this cycle
    hdc_pkg::item_idx_t idx_q;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            idx_q <= '0;
        end else if (!gen) begin
            // parked at item 0 between runs
            idx_q <= '0;
        end else begin
            idx_q <= idx_q + 1'b1;
        end
    end

    // requested item reached, one pulse
    assign item_done = gen && (idx_q == item_num);

endmodule

// ==== xorshift32.sv ====
`timescale 1ns/1ps

module xorshift32 (
    input  logic         S_AXI_ACLK,
    input  logic         S_AXI_ARESETN,
    input  logic         gen,
    output hdc_pkg::hv_t rand_word
);

    hdc_pkg::hv_t state_q;

    // one xorshift step, shifts 13 / 17 / 5
    hdc_pkg::hv_t step_a;
    hdc_pkg::hv_t step_b;
    hdc_pkg::hv_t step_next;

    always_comb begin
        step_a    = state_q ^ (state_q << 13);
        step_b    = step_a ^ (step_a >> 17);
        step_next = step_b ^ (step_b << 5);
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state_q <= hdc_pkg::HV_SEED;
        end else if (!gen) begin
            // every run replays the same sequence
            state_q <= hdc_pkg::HV_SEED;
        end else begin
            state_q <= step_next;
        end
    end

    assign rand_word = state_q;

    // a zero state would lock the generator
    a_nonzero: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        state_q != '0);

endmodule

// ==== hdc_top.sv ====
`timescale 1ns/1ps

module hdc_top (
    input  logic                            S_AXI_ACLK,
    input  logic                            S_AXI_ARESETN,
    // write address
    input  logic [hdc_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    // write data
    input  hdc_pkg::data_t                  s_axi_wdata,
    input  logic [3:0]                      s_axi_wstrb,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,
    // write response
    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,
    // read address
    input  logic [hdc_pkg::AXIL_ADDR_W-1:0] s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    // read data
    output hdc_pkg::data_t                  s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready
);

    // generator side wires
    logic               gen;
    logic               item_done;
    hdc_pkg::item_idx_t item_num;
    hdc_pkg::hv_t       rand_word;

    reg_bus_if bus ();

    // ==================================================
    // bus side
    // ==================================================
    axil_fsm fsm0 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .bus           (bus.fsm)
    );

    hdc_regs regs0 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .bus           (bus.regs),
        .item_done     (item_done),
        .rand_word     (rand_word),
        .gen           (gen),
        .item_num      (item_num),
        .rdata         (s_axi_rdata)
    );

    // ==================================================
    // item memory generator
    // ==================================================
    item_counter cnt0 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_num      (item_num),
        .item_done     (item_done)
    );

    xorshift32 prng0 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .rand_word     (rand_word)
    );

endmodule

// ==== tb_hdc_top.sv ====
`timescale 1ns/1ps

module tb_hdc_top;

    // bus transfer orderings for writes
    localparam logic [1:0] ORD_AW_FIRST = 2'd0;
    localparam logic [1:0] ORD_W_FIRST  = 2'd1;
    localparam logic [1:0] ORD_BOTH     = 2'd2;
    localparam int         WAIT_LIMIT   = 50;
    // a run of up to 200 cycles, several cycles per poll read
    localparam int         POLL_LIMIT   = 200;

    typedef struct packed {
        logic           is_write;
        logic [31:0]    addr;
        hdc_pkg::data_t data;
        hdc_pkg::data_t exp_rd;
        logic [1:0]     order;
    } txn_t;

    logic                            S_AXI_ACLK;
    logic                            S_AXI_ARESETN;
    logic [hdc_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr;
    logic                            s_axi_awvalid;
    logic                            s_axi_awready;
    hdc_pkg::data_t                  s_axi_wdata;
    logic [3:0]                      s_axi_wstrb;
    logic                            s_axi_wvalid;
    logic                            s_axi_wready;
    logic [1:0]                      s_axi_bresp;
    logic                            s_axi_bvalid;
    logic                            s_axi_bready;
    logic [hdc_pkg::AXIL_ADDR_W-1:0] s_axi_araddr;
    logic                            s_axi_arvalid;
    logic                            s_axi_arready;
    hdc_pkg::data_t                  s_axi_rdata;
    logic [1:0]                      s_axi_rresp;
    logic                            s_axi_rvalid;
    logic                            s_axi_rready;

    txn_t        table_q[$];
    logic [31:0] rng_state;

    hdc_top dut0 (.*);

    // 4 ns clock
    initial begin
        S_AXI_ACLK = 1'b0;
        forever begin
            #2 S_AXI_ACLK = ~S_AXI_ACLK;
        end
    end

    // ==================================================
    // failure reporting and compares
    // ==================================================
    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_data(input string name, input hdc_pkg::data_t got,
                              input hdc_pkg::data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_hv(input string name, input hdc_pkg::hv_t got,
                            input hdc_pkg::hv_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got,
                              input logic [1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // stimulus prng, shifts 13 / 17 / 5
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // expected vector: seed advanced n times
    function automatic hdc_pkg::hv_t model_item_hv(input int n);
        hdc_pkg::hv_t s;
        s = hdc_pkg::HV_SEED;
        for (int i = 0; i < n; i++) begin
            s = s ^ (s << 13);
            s = s ^ (s >> 17);
            s = s ^ (s << 5);
        end
        return s;
    endfunction

    // ==================================================
    // bus tasks, entered and left on a falling edge
    // ==================================================
    // readies sampled 1 ns after the falling edge, before the rising edge
    task automatic send_beats(input logic do_aw, input logic do_w);
        int   waited;
        logic aw_hit;
        logic w_hit;
        waited        = 0;
        s_axi_awvalid = do_aw;
        s_axi_wvalid  = do_w;
        while (s_axi_awvalid || s_axi_wvalid) begin
            #1;
            aw_hit = s_axi_awvalid && s_axi_awready;
            w_hit  = s_axi_wvalid && s_axi_wready;
            @(negedge S_AXI_ACLK);
            if (aw_hit) begin
                s_axi_awvalid = 1'b0;
            end
            if (w_hit) begin
                s_axi_wvalid = 1'b0;
            end
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_problem(s_axi_awvalid ? "timeout waiting for awready"
                                             : "timeout waiting for wready");
            end
        end
    endtask

    // slave must sit still while the response is stalled
    task automatic check_stalled();
        if (s_axi_awready || s_axi_wready || s_axi_arready) begin
            report_problem("a ready went high while a response was pending");
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input hdc_pkg::data_t data,
                              input logic [1:0] order, input int stall);
        int waited;
        s_axi_awaddr = addr;
        s_axi_wdata  = data;
        case (order)
            ORD_AW_FIRST: begin
                send_beats(1'b1, 1'b0);
                send_beats(1'b0, 1'b1);
            end
            ORD_W_FIRST: begin
                send_beats(1'b0, 1'b1);
                send_beats(1'b1, 1'b0);
            end
            default: send_beats(1'b1, 1'b1);
        endcase
        waited = 0;
        while (!s_axi_bvalid) begin
            @(negedge S_AXI_ACLK);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_problem("timeout waiting for bvalid");
            end
        end
        // commit cycle, then the response
        if (waited != 1) begin
            report_problem("bvalid did not rise two cycles after the write was accepted");
        end
        check_resp("s_axi_bresp", s_axi_bresp, hdc_pkg::RESP_OKAY);
        check_stalled();
        repeat (stall) begin
            @(negedge S_AXI_ACLK);
            if (!s_axi_bvalid) begin
                report_problem("bvalid dropped before bready");
            end
            check_stalled();
        end
        s_axi_bready = 1'b1;
        @(negedge S_AXI_ACLK);
        s_axi_bready = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, input int stall,
                             output hdc_pkg::data_t data);
        int   waited;
        logic ar_hit;
        waited        = 0;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        while (s_axi_arvalid) begin
            #1;
            ar_hit = s_axi_arready;
            @(negedge S_AXI_ACLK);
            if (ar_hit) begin
                s_axi_arvalid = 1'b0;
            end
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_problem("timeout waiting for arready");
            end
        end
        waited = 0;
        while (!s_axi_rvalid) begin
            @(negedge S_AXI_ACLK);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_problem("timeout waiting for rvalid");
            end
        end
        // one fetch cycle before the response
        if (waited != 1) begin
            report_problem("rvalid did not rise two cycles after the read was accepted");
        end
        data = s_axi_rdata;
        check_resp("s_axi_rresp", s_axi_rresp, hdc_pkg::RESP_OKAY);
        check_stalled();
        repeat (stall) begin
            @(negedge S_AXI_ACLK);
            if (!s_axi_rvalid) begin
                report_problem("rvalid dropped before rready");
            end
            check_data("s_axi_rdata", s_axi_rdata, data);
            check_stalled();
        end
        s_axi_rready = 1'b1;
        @(negedge S_AXI_ACLK);
        s_axi_rready = 1'b0;
    endtask

    task automatic add_txn(input logic is_write, input logic [31:0] addr,
                           input hdc_pkg::data_t data, input hdc_pkg::data_t exp_rd,
                           input logic [1:0] order);
        table_q.push_back({is_write, addr, data, exp_rd, order});
    endtask

    // one generation run, returns the captured vector
    task automatic run_generation(input int n, output hdc_pkg::hv_t hv);
        hdc_pkg::data_t rd;
        int             polls;
        polls = 0;
        write_word(32'h04, hdc_pkg::data_t'(n), ORD_BOTH, 0);
        write_word(32'h00, 32'h1, ORD_BOTH, 0);
        read_word(32'h00, 0, rd);
        while (rd[0]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                report_problem("timeout waiting for the generate bit to clear");
            end
            read_word(32'h00, 0, rd);
        end
        read_word(32'h08, int'(next_rand() % 6), rd);
        hv = hdc_pkg::hv_t'(rd);
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        hdc_pkg::data_t rd;
        hdc_pkg::hv_t   hv_a;
        hdc_pkg::hv_t   hv_b;
        txn_t           t;
        int             n;
        rng_state     = 32'ha6c2cf88;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 4'hf;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        repeat (5) @(posedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);

        // reset values, mapped and unmapped
        add_txn(1'b0, 32'h000, '0, 32'h0, ORD_BOTH);
        add_txn(1'b0, 32'h004, '0, 32'h0, ORD_BOTH);
        add_txn(1'b0, 32'h008, '0, 32'h0, ORD_BOTH);
        add_txn(1'b0, 32'h040, '0, 32'h0, ORD_BOTH);
        // count keeps the low half
        add_txn(1'b1, 32'h004, 32'habcd_1234, '0, ORD_AW_FIRST);
        add_txn(1'b0, 32'h004, '0, 32'h0000_1234, ORD_BOTH);
        // outside the register window, no effect
        add_txn(1'b1, 32'h404, 32'h0000_5555, '0, ORD_BOTH);
        add_txn(1'b0, 32'h004, '0, 32'h0000_1234, ORD_BOTH);
        add_txn(1'b0, 32'h404, '0, 32'h0, ORD_BOTH);
        // hv is read only
        add_txn(1'b1, 32'h008, 32'hffff_ffff, '0, ORD_W_FIRST);
        add_txn(1'b0, 32'h008, '0, 32'h0, ORD_BOTH);
        // each ordering commits
        add_txn(1'b1, 32'h004, 32'h0000_0077, '0, ORD_W_FIRST);
        add_txn(1'b0, 32'h004, '0, 32'h0000_0077, ORD_BOTH);
        add_txn(1'b1, 32'h004, 32'h0000_beef, '0, ORD_BOTH);
        add_txn(1'b0, 32'h004, '0, 32'h0000_beef, ORD_BOTH);
        add_txn(1'b1, 32'h004, 32'h0000_0001, '0, ORD_AW_FIRST);
        add_txn(1'b0, 32'h004, '0, 32'h0000_0001, ORD_BOTH);

        foreach (table_q[i]) begin
            t = table_q[i];
            if (t.is_write) begin
                write_word(t.addr, t.data, t.order, int'(next_rand() % 6));
            end else begin
                read_word(t.addr, int'(next_rand() % 6), rd);
                check_data("s_axi_rdata", rd, t.exp_rd);
            end
        end

        // generation runs, each repeated with the same count
        repeat (3) begin
            n = int'(next_rand() % 200);
            run_generation(n, hv_a);
            check_hv("item hv", hv_a, model_item_hv(n));
            // other count in between so the repeat must capture again
            run_generation(n ^ 1, hv_b);
            check_hv("other item hv", hv_b, model_item_hv(n ^ 1));
            run_generation(n, hv_b);
            check_hv("repeat item hv", hv_b, hv_a);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== src.f ====
hdc_pkg.sv
reg_bus_if.sv
axil_fsm.sv
hdc_regs.sv
item_counter.sv
xorshift32.sv
hdc_top.sv
tb_hdc_top.sv

// ==== Bender.yml ====
package:
  name: hdc_item_memory

sources:
  - hdc_pkg.sv
  - reg_bus_if.sv
  - axil_fsm.sv
  - hdc_regs.sv
  - item_counter.sv
  - xorshift32.sv
  - hdc_top.sv
  - target: simulation
    files:
      - tb_hdc_top.sv
